//--- test/prenorm_stimulus.txt
# M addr lane3 lane2 lane1 lane0   memory vector in hex, other addresses hold a fill pattern
# T start end max                  range start..end-1 in hex and its expected maximum
M 00 0100 0080 ff00 0000
M 01 0200 fe00 0040 0010
M 02 0180 0300 ffff 8001
M 03 00c0 0000 0280 fc00
M 10 ff00 fe80 fff0 c000
M 11 ff80 8000 e000 fffe
M 12 fc00 f000 ff10 ffc0
M 20 7fff 8000 0100 8001
M 21 0000 c000 7000 ffff
T 00 04 0300
T 10 13 fffe
T 20 22 7fff
T 30 30 0000
T 02 03 0300
T 40 44 6183
T 00 22 7fff

//--- list.f
verilog/softmax_pkg.sv
verilog/pass_ctrl_if.sv
verilog/prenorm_ctrl.sv
verilog/vector_buffer.sv
verilog/lane_max_tree.sv
verilog/max_subtract.sv
verilog/softmax_prenorm.sv
test/prenorm_checker.sv
test/prenorm_monitor.sv
test/tb_softmax_prenorm.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      := --timing --assert
TOP        := tb_softmax_prenorm
FILELIST   := list.f
BUILD_DIR  := obj_dir
LOG        := sim.log
SIM_ARGS   := +verilator+error+limit+1000
PASS_MSG   := Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/tb_softmax_prenorm.sv
`timescale 1ns/1ps
`default_nettype none

module tb_softmax_prenorm import softmax_pkg::*; ();

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 3;
  localparam int TEST_MARGIN  = 20;

  logic  clk;
  logic  reset;
  logic  start;
  addr_t start_addr;
  addr_t end_addr;
  vec_t  mem_data = '0;
  addr_t mem_addr;
  vec_t  result;
  logic  result_valid;
  logic  busy;
  logic  done;

  vec_t  mem_image [BUF_DEPTH];
  addr_t test_start [$];
  addr_t test_end [$];
  elem_t test_max [$];

  addr_t cur_start;
  addr_t cur_end;
  elem_t cur_max;
  int    test_num;
  logic  tests_done;
  int    error_count;
  int    watchdog_cycles = 0;

  softmax_prenorm i_dut (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .start_addr   (start_addr),
    .end_addr     (end_addr),
    .mem_data     (mem_data),
    .mem_addr     (mem_addr),
    .result       (result),
    .result_valid (result_valid),
    .busy         (busy),
    .done         (done)
  );

  prenorm_monitor i_monitor (
    .clk          (clk),
    .reset        (reset),
    .result       (result),
    .result_valid (result_valid),
    .done         (done),
    .mem_image    (mem_image),
    .cur_start    (cur_start),
    .cur_end      (cur_end),
    .cur_max      (cur_max),
    .test_num     (test_num),
    .tests_done   (tests_done),
    .error_count  (error_count)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // memory answers one cycle after the address
  always @(posedge clk) begin
    mem_data <= mem_image[mem_addr];
  end

  // background pattern, unique per address and lane
  function automatic elem_t fill_elem(input addr_t addr, input int lane);
    logic [1:0] lane_bits;
    lane_bits = lane[1:0];
    return {2'b01, addr, 5'b00000, lane_bits};
  endfunction

  function automatic int range_len(input addr_t first, input addr_t last);
    return (last > first) ? int'(last) - int'(first) : 0;
  endfunction

  task automatic read_stimulus(output bit ok);
    int          fd;
    int          code;
    string       line;
    logic [31:0] f0, f1, f2, f3, f4;
    for (int a = 0; a < BUF_DEPTH; a++) begin
      for (int l = 0; l < LANE_COUNT; l++) begin
        mem_image[a][l*ELEM_WIDTH +: ELEM_WIDTH] = fill_elem(addr_t'(a), l);
      end
    end
    fd = $fopen("test/prenorm_stimulus.txt", "r");
    ok = (fd != 0);
    while (ok && !$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      if (code > 0 && line.getc(0) == "M") begin
        code = $sscanf(line, "M %h %h %h %h %h", f0, f1, f2, f3, f4);
        mem_image[f0[ADDR_WIDTH-1:0]] = {f1[15:0], f2[15:0], f3[15:0], f4[15:0]};
      end else if (code > 0 && line.getc(0) == "T") begin
        code = $sscanf(line, "T %h %h %h", f0, f1, f2);
        test_start.push_back(f0[ADDR_WIDTH-1:0]);
        test_end.push_back(f1[ADDR_WIDTH-1:0]);
        test_max.push_back(f2[15:0]);
      end
    end
    if (ok) begin
      $fclose(fd);
    end
  endtask

  task automatic run_test(input int idx);
    int n;
    n = range_len(test_start[idx], test_end[idx]);
    @(posedge clk);
    cur_start  <= test_start[idx];
    cur_end    <= test_end[idx];
    cur_max    <= test_max[idx];
    test_num   <= idx + 1;
    start      <= 1'b1;
    start_addr <= test_start[idx];
    end_addr   <= test_end[idx];
    @(posedge clk);
    start <= 1'b0;
    if (n > 0) begin
      // a second start while busy must be ignored
      repeat (2) @(posedge clk);
      start      <= 1'b1;
      start_addr <= '0;
      end_addr   <= addr_t'(BUF_DEPTH - 1);
      @(posedge clk);
      start <= 1'b0;
    end
    while (!done) @(posedge clk);
    @(posedge clk);
  endtask

  initial begin
    bit loaded;
    reset      <= 1'b1;
    start      <= 1'b0;
    start_addr <= '0;
    end_addr   <= '0;
    cur_start  <= '0;
    cur_end    <= '0;
    cur_max    <= '0;
    test_num   <= 0;
    tests_done <= 1'b0;
    read_stimulus(loaded);
    if (!loaded || test_start.size() == 0) begin
      $display("stimulus file could not be read or holds no tests");
      $display("Verification failed");
      $finish;
    end else begin
      watchdog_cycles = RESET_CYCLES + 10;
      foreach (test_start[i]) begin
        watchdog_cycles += range_len(test_start[i], test_end[i]) + TEST_MARGIN;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      foreach (test_start[i]) begin
        run_test(i);
      end
      tests_done <= 1'b1;
      repeat (2) @(posedge clk);
      if (error_count == 0 && i_dut.i_checker.assert_failures == 0) begin
        $display("Verification passed");
      end else begin
        $display("Verification failed");
      end
      $finish;
    end
  end

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: run still going after %0d cycles", watchdog_cycles);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/prenorm_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module prenorm_monitor import softmax_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  vec_t  result,
  input  logic  result_valid,
  input  logic  done,
  input  vec_t  mem_image [BUF_DEPTH],
  input  addr_t cur_start,
  input  addr_t cur_end,
  input  elem_t cur_max,
  input  int    test_num,
  input  logic  tests_done,
  output int    error_count
);

  int   result_count;
  int   test_errors;
  int   tests_run;
  int   tests_bad;
  logic summary_done;

  // element minus max, floored at the most negative element
  function automatic elem_t expected_lane(input elem_t value, input elem_t max_value);
    int diff;
    diff = int'(value) - int'(max_value);
    return (diff < int'(ELEM_MIN)) ? ELEM_MIN : elem_t'(diff);
  endfunction

  function automatic int range_len();
    return (cur_end > cur_start) ? int'(cur_end) - int'(cur_start) : 0;
  endfunction

  task automatic check_vector();
    addr_t addr;
    vec_t  source;
    elem_t want;
    elem_t got;
    addr   = cur_start + addr_t'(result_count);
    source = mem_image[addr];
    if (result_count >= range_len()) begin
      $display("test %0d: result vector beyond the end of the range", test_num);
      test_errors++;
      error_count++;
    end else begin
      for (int l = 0; l < LANE_COUNT; l++) begin
        want = elem_t'(source[l*ELEM_WIDTH +: ELEM_WIDTH]);
        want = expected_lane(want, cur_max);
        got  = elem_t'(result[l*ELEM_WIDTH +: ELEM_WIDTH]);
        if (got !== want) begin
          $display("MISMATCH test %0d addr %02h lane %0d: result = %04h, expected %04h",
                   test_num, addr, l, got, want);
          test_errors++;
          error_count++;
        end
      end
    end
    result_count++;
  endtask

  always @(posedge clk) begin
    if (reset) begin
      result_count = 0;
      test_errors  = 0;
      tests_run    = 0;
      tests_bad    = 0;
      error_count  = 0;
      summary_done = 1'b0;
    end else begin
      if (result_valid) begin
        check_vector();
      end
      if (done) begin
        if (result_count != range_len()) begin
          $display("test %0d: saw %0d result vectors where the range holds %0d",
                   test_num, result_count, range_len());
          test_errors++;
          error_count++;
        end
        $display("test %0d: range %02h..%02h, max %04h, %0d results, %0d errors",
                 test_num, cur_start, cur_end, cur_max, result_count, test_errors);
        tests_run++;
        if (test_errors > 0) begin
          tests_bad++;
        end
        result_count = 0;
        test_errors  = 0;
      end
      if (tests_done && !summary_done) begin
        $display("summary: %0d tests, %0d with errors, %0d errors in total",
                 tests_run, tests_bad, error_count);
        summary_done = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- test/prenorm_checker.sv
`timescale 1ns/1ps
`default_nettype none

module prenorm_checker import softmax_pkg::*; (
  input logic clk,
  input logic reset,
  input logic start,
  input logic busy,
  input logic done,
  input logic result_valid,
  input vec_t result
);

  int assert_failures = 0;

  a_reset_idle: assert property (@(posedge clk)
    reset |=> !busy && !done && !result_valid && result == '0)
    else begin
      $error("outputs not idle after reset");
      assert_failures++;
    end

  // done right after the last result, with busy already low
  a_done_busy: assert property (@(posedge clk) disable iff (reset)
    $fell(result_valid) |-> done && !busy)
    else begin
      $error("done missing or busy still high after the last result");
      assert_failures++;
    end

  a_done_single: assert property (@(posedge clk) disable iff (reset)
    done |=> !done && !busy)
    else begin
      $error("done longer than one cycle or busy back too early");
      assert_failures++;
    end

  a_valid_busy: assert property (@(posedge clk) disable iff (reset) result_valid |-> busy)
    else begin
      $error("result_valid outside a busy run");
      assert_failures++;
    end

  // a start during a run neither restarts nor aborts it
  a_start_ignored: assert property (@(posedge clk) disable iff (reset)
    start && busy |=> busy || done)
    else begin
      $error("start while busy disturbed the run");
      assert_failures++;
    end

endmodule

bind softmax_prenorm prenorm_checker i_checker (
  .clk          (clk),
  .reset        (reset),
  .start        (start),
  .busy         (busy),
  .done         (done),
  .result_valid (result_valid),
  .result       (result)
);

`default_nettype wire

//--- verilog/softmax_prenorm.sv
`timescale 1ns/1ps
`default_nettype none

module softmax_prenorm import softmax_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  start,
  input  addr_t start_addr,
  input  addr_t end_addr,
  input  vec_t  mem_data,
  output addr_t mem_addr,
  output vec_t  result,
  output logic  result_valid,
  output logic  busy,
  output logic  done
);

  pass_ctrl_if ctl_if ();

  vec_t  buf_rd_data;
  elem_t max_value;

  prenorm_ctrl i_ctrl (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .start_addr (start_addr),
    .end_addr   (end_addr),
    .mem_addr   (mem_addr),
    .busy       (busy),
    .done       (done),
    .ctl        (ctl_if.ctrl)
  );

  // memory data goes to the buffer and the max tree together
  vector_buffer i_buffer (
    .clk     (clk),
    .wr_data (mem_data),
    .rd_data (buf_rd_data),
    .ctl     (ctl_if.dp)
  );

  lane_max_tree i_max_tree (
    .clk     (clk),
    .reset   (reset),
    .vec_in  (mem_data),
    .max_out (max_value),
    .ctl     (ctl_if.dp)
  );

  // replayed buffer minus the range max
  max_subtract i_subtract (
    .clk          (clk),
    .reset        (reset),
    .vec_in       (buf_rd_data),
    .max_in       (max_value),
    .result       (result),
    .result_valid (result_valid),
    .ctl          (ctl_if.dp)
  );

endmodule

`default_nettype wire

//--- verilog/max_subtract.sv
`timescale 1ns/1ps
`default_nettype none

module max_subtract import softmax_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  vec_t    vec_in,
  input  elem_t   max_in,
  output vec_t    result,
  output logic    result_valid,
  pass_ctrl_if.dp ctl
);

  vec_t diff_sat;

  for (genvar i = 0; i < LANE_COUNT; i++) begin : g_lane
    elem_t                 a;
    logic signed [ELEM_WIDTH:0] diff;

    assign a = vec_in[i*ELEM_WIDTH +: ELEM_WIDTH];

    // one extra bit so the difference cannot wrap
    assign diff = {a[ELEM_WIDTH-1], a} - {max_in[ELEM_WIDTH-1], max_in};

    // clamp at the most negative element
    assign diff_sat[i*ELEM_WIDTH +: ELEM_WIDTH] =
      (diff < ELEM_MIN) ? ELEM_MIN : diff[ELEM_WIDTH-1:0];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      result       <= '0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= ctl.sub_en;
      if (ctl.sub_en) begin
        result <= diff_sat;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/lane_max_tree.sv
`timescale 1ns/1ps
`default_nettype none

module lane_max_tree import softmax_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  vec_t    vec_in,
  output elem_t   max_out,
  pass_ctrl_if.dp ctl
);

  function automatic elem_t max2(input elem_t a, input elem_t b);
    return (a > b) ? a : b;
  endfunction

  elem_t lane [LANE_COUNT];
  elem_t max_01;
  elem_t max_23;
  elem_t tree_max;
  elem_t run_max;

  for (genvar i = 0; i < LANE_COUNT; i++) begin : g_lane
    assign lane[i] = vec_in[i*ELEM_WIDTH +: ELEM_WIDTH];
  end

  // first level pairs adjacent lanes
  assign max_01 = max2(lane[0], lane[1]);
  assign max_23 = max2(lane[2], lane[3]);

  assign tree_max = max2(max_01, max_23);

  // running max across the whole load pass
  always_ff @(posedge clk) begin
    if (reset || ctl.max_clear) begin
      run_max <= ELEM_MIN;
    end else if (ctl.load_en) begin
      run_max <= max2(run_max, tree_max);
    end
  end

  assign max_out = run_max;

endmodule

`default_nettype wire

//--- verilog/vector_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module vector_buffer import softmax_pkg::*; (
  input  logic    clk,
  input  vec_t    wr_data,
  output vec_t    rd_data,
  pass_ctrl_if.dp ctl
);

  // indexed by memory address
  vec_t mem [0:BUF_DEPTH-1];

  always_ff @(posedge clk) begin
    if (ctl.load_en) begin
      mem[ctl.wr_addr] <= wr_data;
    end
  end

  // registered read port
  always_ff @(posedge clk) begin
    if (ctl.rd_en) begin
      rd_data <= mem[ctl.rd_addr];
    end
  end

endmodule

`default_nettype wire

//--- verilog/prenorm_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module prenorm_ctrl import softmax_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      start,
  input  addr_t     start_addr,
  input  addr_t     end_addr,
  output addr_t     mem_addr,
  output logic      busy,
  output logic      done,
  pass_ctrl_if.ctrl ctl
);

  ctrl_state_t state;

  addr_t start_q;
  addr_t end_q;
  addr_t last_addr;
  addr_t load_addr;
  addr_t rd_addr;
  addr_t wr_addr_q;

  logic load_en_q;
  logic rd_run;
  logic rd_en;
  logic sub_en_q;
  logic sub_d;
  logic accept;
  logic empty_in;
  logic empty_q;

  assign busy      = (state == LOAD) || (state == DRAIN) || (state == SUBTRACT);
  assign done      = (state == FINISH);
  assign accept    = start && !busy;
  assign empty_in  = (end_addr <= start_addr);
  assign empty_q   = (end_q <= start_q);
  assign last_addr = end_q - addr_t'(1);
  assign rd_en     = (state == SUBTRACT) && rd_run;
  assign mem_addr  = load_addr;

  assign ctl.load_en   = load_en_q;
  assign ctl.wr_addr   = wr_addr_q;
  assign ctl.max_clear = accept;
  assign ctl.rd_en     = rd_en;
  assign ctl.rd_addr   = rd_addr;
  assign ctl.sub_en    = sub_en_q;

  // memory answers one cycle after the address
  always_ff @(posedge clk) begin
    wr_addr_q <= load_addr;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= IDLE;
      load_addr <= '0;
      rd_addr   <= '0;
      rd_run    <= 1'b0;
      load_en_q <= 1'b0;
      sub_en_q  <= 1'b0;
      sub_d     <= 1'b0;
    end else begin
      load_en_q <= (state == LOAD);
      sub_en_q  <= rd_en;
      // mirrors result_valid of the subtractor
      sub_d     <= sub_en_q;
      case (state)
        IDLE, FINISH: begin
          state <= IDLE;
          if (accept) begin
            start_q   <= start_addr;
            end_q     <= end_addr;
            load_addr <= start_addr;
            // empty range skips the load pass
            state     <= empty_in ? DRAIN : LOAD;
          end
        end
        LOAD: begin
          load_addr <= load_addr + addr_t'(1);
          if (load_addr == last_addr) begin
            state <= DRAIN;
          end
        end
        DRAIN: begin
          rd_addr <= start_q;
          rd_run  <= !empty_q;
          state   <= empty_q ? FINISH : SUBTRACT;
        end
        SUBTRACT: begin
          if (rd_run) begin
            rd_addr <= rd_addr + addr_t'(1);
            if (rd_addr == last_addr) begin
              rd_run <= 1'b0;
            end
          end
          // last result is out this cycle
          if (sub_d && !sub_en_q) begin
            state <= FINISH;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/pass_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface pass_ctrl_if import softmax_pkg::*; ();

  // load pass
  logic  load_en;
  addr_t wr_addr;
  logic  max_clear;

  // subtract pass
  logic  rd_en;
  addr_t rd_addr;
  logic  sub_en;

  modport ctrl (
    output load_en,
    output wr_addr,
    output max_clear,
    output rd_en,
    output rd_addr,
    output sub_en
  );

  modport dp (
    input load_en,
    input wr_addr,
    input max_clear,
    input rd_en,
    input rd_addr,
    input sub_en
  );

endinterface

`default_nettype wire

//--- verilog/softmax_pkg.sv
`default_nettype none

package softmax_pkg;

  // vector geometry
  localparam int LANE_COUNT = 4;
  localparam int ELEM_WIDTH = 16;
  localparam int VEC_WIDTH  = LANE_COUNT * ELEM_WIDTH;

  // buffer and memory addressing
  localparam int ADDR_WIDTH = 7;
  localparam int BUF_DEPTH  = 1 << ADDR_WIDTH;

  // signed fixed point, 8 integer and 8 fraction bits
  typedef logic signed [ELEM_WIDTH-1:0] elem_t;

  // lane 0 in the low bits
  typedef logic [VEC_WIDTH-1:0] vec_t;

  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // seed of the running max and floor of the subtraction
  localparam elem_t ELEM_MIN = 16'sh8000;

  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    DRAIN,
    SUBTRACT,
    FINISH
  } ctrl_state_t;

endpackage

`default_nettype wire
